//--- fetch_cases.txt
# columns: kind name a b  (a and b in hex, name - for steps that are not tests)
# mem: a = byte address, b = word; run: a = instructions; stall: a = cycles
# redirect: a = pc, b = 1 waits for a miss; update: a = pc, b = taken
# clear: reset the miss count; misses: a = expected mem_req count
mem img 00000000 00100093
mem img 00000004 00208093
mem img 00000008 00308093
mem img 0000000c 00408093
# jal x0, +0x20 to 0x30
mem img 00000010 0200006f
mem img 00000030 00108093
mem img 00000034 00210113
# beq x0, x0, -8 back to 0x30
mem img 00000038 fe000ce3
mem img 00000100 00318193
mem img 00000104 00420213
# beq x0, x0, -8 back to 0x100
mem img 00000108 fe000ce3
# straight line code from reset
run seq 4 0
# jump into the loop body
run jal 2 0
# first time through the branch is not taken
run branch_nt 3 0
update - 38 1
update - 38 1
# back to the loop while a miss is pending
redirect miss_redirect 30 1
run branch_taken 4 0
stall stall_window c 0
run after_stall 6 0
# train the second loop before entering it
update - 108 1
update - 108 1
clear - 0 0
redirect loop_redirect 100 0
run cache_loop 6 0
misses cache_reuse 3 0

//--- fetch_top.f
fetch_pkg.sv
fetch_mem_if.sv
ifetch.sv
icache.sv
branch_predictor.sv
fetch_top.sv
fetch_top_tb.sv

//--- fetch_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top_tb;

    logic        clk_in;
    logic        br_reset;
    logic        stall;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        out_valid;
    logic [31:0] out_ins;
    logic [31:0] out_pc;
    logic [31:0] out_pred_pc;
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic        upd_taken;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_data;

    logic [31:0] mem_img [logic [31:0]];    // program image from the cases file
    logic [1:0]  ctr_ref [16];              // reference counter table
    logic [1:0]  ctr_last [16];             // counters one edge back
    logic [31:0] exp_pc;
    logic        last_stall;
    int          delivered;
    int          miss_count;
    int          errors;
    int          test_errors;
    int          tests;
    int          limit_cycles;
    string       test_name;

    string       cmd_kind [$];
    string       cmd_name [$];
    logic [31:0] cmd_a [$];
    logic [31:0] cmd_b [$];

    fetch_top fetch_top_i (
        .clk_in         (clk_in),
        .br_reset       (br_reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out_ins        (out_ins),
        .out_pc         (out_pc),
        .out_pred_pc    (out_pred_pc),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_data       (mem_data)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // words outside the image are addi with the address folded in
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (mem_img.exists(addr))
            return mem_img[addr];
        return {addr[31:7] ^ {18'b0, addr[6:0]}, 7'h13};
    endfunction

    // next pc from the jal offset, a taken branch offset or pc + 4
    function automatic logic [31:0] expected_next(input logic [31:0] pc, input logic [31:0] ins);
        logic [31:0] off;
        off = 32'd4;
        if (ins[6:0] == 7'h6f) begin
            off = {ins[31] ? 12'hfff : 12'h000, ins[19:12], ins[20], ins[30:21], 1'b0};
        end else if (ins[6:0] == 7'h63 && ctr_last[pc[5:2]] >= 2'd2) begin
            off = {ins[31] ? 20'hfffff : 20'h00000, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        return pc + off;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // compare any delivery on one clock edge, then follow training and redirect
    task automatic clock_step();
        logic [31:0] ins;
        logic [31:0] nxt;
        @(posedge clk_in);
        if (out_valid) begin
            if (last_stall) begin
                $display("%s: out_valid was high although stall was held", test_name);
                errors++;
                test_errors++;
            end
            ins = fetch_word(exp_pc);
            nxt = expected_next(exp_pc, ins);
            check_value("out_pc", exp_pc, out_pc);
            check_value("out_ins", ins, out_ins);
            check_value("out_pred_pc", nxt, out_pred_pc);
            exp_pc = nxt;
            delivered++;
        end
        ctr_last = ctr_ref;     // table the next delivery was predicted with
        if (upd_valid) begin
            if (upd_taken && ctr_ref[upd_pc[5:2]] != 2'd3)
                ctr_ref[upd_pc[5:2]]++;
            else if (!upd_taken && ctr_ref[upd_pc[5:2]] != 2'd0)
                ctr_ref[upd_pc[5:2]]--;
        end
        if (redirect_valid)
            exp_pc = redirect_pc;   // fetch restarts here
        last_stall = stall;
    endtask

    task automatic read_cases();
        int          fd;
        int          r;
        string       tok;
        string       name;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open fetch_cases.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    r = $fgets(rest, fd);
                end else begin
                    r = $fscanf(fd, "%s %h %h", name, a, b);
                    if (tok == "mem") begin
                        mem_img[a] = b;
                    end else begin
                        cmd_kind.push_back(tok);
                        cmd_name.push_back(name);
                        cmd_a.push_back(a);
                        cmd_b.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // memory answers after 1 to 4 cycles
    initial begin
        int delay;
        void'($urandom(86));
        forever begin
            @(posedge clk_in);
            if (mem_req && !mem_ack) begin
                miss_count++;
                delay = 1 + ($urandom % 4);
                repeat (delay - 1) @(posedge clk_in);
                mem_data <= fetch_word(mem_addr);
                mem_ack  <= 1'b1;
                do @(posedge clk_in); while (mem_req);
                mem_ack  <= 1'b0;
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_in);
        $display("timeout: fetch did not finish within %0d cycles", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int target;
        br_reset       <= 1'b1;
        stall          <= 1'b0;
        redirect_valid <= 1'b0;
        redirect_pc    <= '0;
        upd_valid      <= 1'b0;
        upd_pc         <= '0;
        upd_taken      <= 1'b0;
        mem_ack        <= 1'b0;
        mem_data       <= '0;
        exp_pc     = '0;
        last_stall = 1'b0;
        test_name  = "reset";
        for (int i = 0; i < 16; i++) begin
            ctr_ref[i]  = 2'd1;
            ctr_last[i] = 2'd1;
        end
        read_cases();
        limit_cycles = 400;
        foreach (cmd_kind[i]) begin
            if (cmd_kind[i] == "run")
                limit_cycles += cmd_a[i] * 40;
            if (cmd_kind[i] == "stall")
                limit_cycles += cmd_a[i];
        end
        repeat (2) @(posedge clk_in);
        br_reset <= 1'b0;
        foreach (cmd_kind[i]) begin
            test_name   = cmd_name[i];
            test_errors = 0;
            case (cmd_kind[i])
                "run": begin
                    target = delivered + cmd_a[i];
                    while (delivered < target)
                        clock_step();
                end
                "stall": begin
                    stall <= 1'b1;
                    repeat (cmd_a[i]) clock_step();
                    stall <= 1'b0;
                end
                "redirect": begin
                    if (cmd_b[i] != 0) begin
                        do clock_step(); while (!mem_req);   // land inside a miss
                    end
                    redirect_valid <= 1'b1;
                    redirect_pc    <= cmd_a[i];
                    clock_step();
                    redirect_valid <= 1'b0;
                end
                "update": begin
                    upd_valid <= 1'b1;
                    upd_pc    <= cmd_a[i];
                    upd_taken <= cmd_b[i][0];
                    clock_step();
                    upd_valid <= 1'b0;
                end
                "clear": miss_count = 0;
                "misses": check_value("mem_req count", cmd_a[i], miss_count);
                default: begin
                    $display("unknown command %s in fetch_cases.txt", cmd_kind[i]);
                    errors++;
                end
            endcase
            if (cmd_name[i] != "-") begin
                tests++;
                if (test_errors == 0)
                    $display("test %s: ok", test_name);
                else
                    $display("test %s: %0d errors", test_name, test_errors);
            end
        end
        $display("%0d tests, %0d instructions, %0d errors", tests, delivered, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int CACHE_INDEX_BITS = 4,
    parameter int BP_INDEX_BITS    = 4
) (
    input  logic  clk_in,
    input  logic  br_reset,
    input  logic  stall,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,

    // decoder side
    output logic  out_valid,
    output word_t out_ins,
    output addr_t out_pc,
    output addr_t out_pred_pc,

    // predictor training
    input  logic  upd_valid,
    input  addr_t upd_pc,
    input  logic  upd_taken,

    // instruction memory
    output logic  mem_req,
    output addr_t mem_addr,
    input  logic  mem_ack,
    input  word_t mem_data
);

    addr_t query_pc;
    word_t query_ins;
    addr_t pred_pc;

    fetch_mem_if fm_if ();

    ifetch ifetch_i (
        .clk_in         (clk_in),
        .br_reset       (br_reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fm             (fm_if.fetcher),
        .query_pc       (query_pc),
        .query_ins      (query_ins),
        .pred_pc        (pred_pc),
        .out_valid      (out_valid),
        .out_ins        (out_ins),
        .out_pc         (out_pc),
        .out_pred_pc    (out_pred_pc)
    );

    icache #(
        .CACHE_INDEX_BITS (CACHE_INDEX_BITS)
    ) icache_i (
        .clk_in   (clk_in),
        .br_reset (br_reset),
        .fm       (fm_if.cache),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    branch_predictor #(
        .BP_INDEX_BITS (BP_INDEX_BITS)
    ) branch_predictor_i (
        .clk_in    (clk_in),
        .br_reset  (br_reset),
        .query_pc  (query_pc),
        .query_ins (query_ins),
        .pred_pc   (pred_pc),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken)
    );

endmodule

`default_nettype wire

//--- branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor import fetch_pkg::*; #(
    parameter int BP_INDEX_BITS = 4
) (
    input  logic  clk_in,
    input  logic  br_reset,

    // prediction port answered combinationally
    input  addr_t query_pc,
    input  word_t query_ins,
    output addr_t pred_pc,

    // training from the back end
    input  logic  upd_valid,
    input  addr_t upd_pc,
    input  logic  upd_taken
);

    localparam int ENTRIES = 1 << BP_INDEX_BITS;

    typedef logic [1:0]               counter_t;
    typedef logic [BP_INDEX_BITS-1:0] bp_index_t;

    counter_t  ctr_q [ENTRIES];
    bp_index_t q_idx;
    bp_index_t u_idx;
    opcode_t   opcode;
    logic      taken;

    // pcs are word aligned so bits 1:0 are skipped
    assign q_idx  = query_pc[BP_INDEX_BITS+1:2];
    assign u_idx  = upd_pc[BP_INDEX_BITS+1:2];
    assign opcode = query_ins[6:0];

    // upper counter bit set means taken
    assign taken = (opcode == OP_BRANCH) && ctr_q[q_idx][1];

    assign pred_pc = taken ? query_pc + imm_b(query_ins) : query_pc + 32'd4;

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= 2'b01;  // weakly not taken
            end
        end else if (upd_valid) begin
            if (upd_taken) begin
                if (ctr_q[u_idx] != 2'b11) begin
                    ctr_q[u_idx] <= ctr_q[u_idx] + 2'b01;
                end
            end else begin
                if (ctr_q[u_idx] != 2'b00) begin
                    ctr_q[u_idx] <= ctr_q[u_idx] - 2'b01;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache import fetch_pkg::*; #(
    parameter int CACHE_INDEX_BITS = 4
) (
    input  logic       clk_in,
    input  logic       br_reset,

    fetch_mem_if.cache fm,

    // four-phase external instruction memory
    output logic       mem_req,
    output addr_t      mem_addr,
    input  logic       mem_ack,
    input  word_t      mem_data
);

    localparam int LINES    = 1 << CACHE_INDEX_BITS;
    localparam int TAG_BITS = 30 - CACHE_INDEX_BITS;   // word address above the index

    typedef logic [CACHE_INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]         tag_t;

    cache_state_t     state;
    word_t            data_mem [LINES];
    tag_t             tag_mem  [LINES];
    logic [LINES-1:0] valid_q;

    index_t req_idx;
    tag_t   req_tag;
    index_t fill_idx;
    tag_t   fill_tag;
    logic   hit;
    logic   new_req;
    logic   start_miss;
    logic   fill;

    assign req_idx  = fm.addr[CACHE_INDEX_BITS+1:2];
    assign req_tag  = fm.addr[31:CACHE_INDEX_BITS+2];
    assign fill_idx = mem_addr[CACHE_INDEX_BITS+1:2];
    assign fill_tag = mem_addr[31:CACHE_INDEX_BITS+2];

    assign hit        = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign new_req    = (state == READY) && fm.req && !fm.ack;  // not yet answered
    assign start_miss = new_req && !hit;
    assign fill       = (state == MEM_REQ) && mem_ack;

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            state   <= READY;
            valid_q <= '0;
            fm.ack  <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                READY: begin
                    if (new_req) begin
                        if (hit) begin
                            fm.ack <= 1'b1;
                        end else begin
                            mem_req <= 1'b1;
                            state   <= MEM_REQ;
                        end
                    end else if (!fm.req && fm.ack) begin
                        fm.ack <= 1'b0;     // fetcher let go
                    end
                end
                MEM_REQ: begin
                    if (fill) begin
                        mem_req           <= 1'b0;
                        valid_q[fill_idx] <= 1'b1;
                        state             <= MEM_DONE;
                    end
                end
                MEM_DONE: begin
                    // memory side closes before the fetcher sees ack
                    if (!mem_ack) begin
                        fm.ack <= 1'b1;
                        state  <= READY;
                    end
                end
                default: state <= READY;
            endcase
        end
    end

    // line storage and returned word
    always_ff @(posedge clk_in) begin
        if (new_req && hit) begin
            fm.data <= data_mem[req_idx];
        end
        if (start_miss) begin
            mem_addr <= fm.addr;
        end
        if (fill) begin
            data_mem[fill_idx] <= mem_data;
            tag_mem[fill_idx]  <= fill_tag;
            fm.data            <= mem_data;
        end
    end

    // the miss address follows a request the fetcher holds steady
    a_mem_addr_stable: assert property (
        @(posedge clk_in) disable iff (br_reset)
        mem_req |-> mem_addr == fm.addr && $stable(fm.addr)
    );

endmodule

`default_nettype wire

//--- ifetch.sv
`timescale 1ns/100ps
`default_nettype none

module ifetch import fetch_pkg::*; (
    input  logic         clk_in,
    input  logic         br_reset,
    input  logic         stall,
    input  logic         redirect_valid,
    input  addr_t        redirect_pc,

    fetch_mem_if.fetcher fm,

    // branch predictor
    output addr_t        query_pc,
    output word_t        query_ins,
    input  addr_t        pred_pc,

    // toward the decoder
    output logic         out_valid,
    output word_t        out_ins,
    output addr_t        out_pc,
    output addr_t        out_pred_pc
);

    fetch_state_t state;
    addr_t        pc;
    addr_t        next_pc;
    opcode_t      opcode;
    logic         launch;   // start a new request this edge
    logic         deliver;  // hand the fetched word to the decoder

    assign query_pc  = pc;
    assign query_ins = fm.data;
    assign opcode    = fm.data[6:0];

    // jal resolved here, everything else from the predictor
    assign next_pc = (opcode == OP_JAL) ? pc + imm_j(fm.data) : pred_pc;

    assign launch  = (state == IDLE) && !stall && !redirect_valid;
    assign deliver = (state == WAIT_ACK) && fm.ack && !stall && !redirect_valid;

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            state     <= IDLE;
            pc        <= '0;
            fm.req    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;  // single cycle pulse
            if (redirect_valid) begin
                pc <= redirect_pc;
                // anything in flight is thrown away
                if (state != IDLE) begin
                    state <= DROP_ACK;
                end
                if (fm.req && fm.ack) begin
                    fm.req <= 1'b0;
                end
            end else begin
                case (state)
                    IDLE: begin
                        if (launch) begin
                            fm.req <= 1'b1;
                            state  <= WAIT_ACK;
                        end
                    end
                    WAIT_ACK: begin
                        // with stall high the ack is simply held
                        if (deliver) begin
                            fm.req    <= 1'b0;
                            pc        <= next_pc;
                            out_valid <= 1'b1;
                            state     <= DROP_ACK;   // now wait for ack to fall
                        end
                    end
                    DROP_ACK: begin
                        if (fm.req && fm.ack) begin
                            fm.req <= 1'b0;
                        end else if (!fm.req && !fm.ack) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // request address and decoder payload
    always_ff @(posedge clk_in) begin
        if (launch) begin
            fm.addr <= pc;
        end
        if (deliver) begin
            out_ins     <= fm.data;
            out_pc      <= pc;
            out_pred_pc <= next_pc;
        end
    end

    // the cache must have closed the previous handshake
    a_req_after_ack_low: assert property (
        @(posedge clk_in) disable iff (br_reset)
        $rose(fm.req) |-> !fm.ack
    );

    a_valid_one_cycle: assert property (
        @(posedge clk_in) disable iff (br_reset)
        out_valid |=> !out_valid
    );

endmodule

`default_nettype wire

//--- fetch_mem_if.sv
`timescale 1ns/100ps
`default_nettype none

// four-phase link where req rises, ack rises, req falls, then ack falls
interface fetch_mem_if import fetch_pkg::*; ();

    logic  req;     // held until ack is seen
    addr_t addr;    // stable while req is high
    logic  ack;
    word_t data;    // valid while ack is high

    modport fetcher (
        output req,
        output addr,
        input  ack,
        input  data
    );

    modport cache (
        input  req,
        input  addr,
        output ack,
        output data
    );

endinterface

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;    // instruction or data word
    typedef logic [31:0] addr_t;    // byte address / pc
    typedef logic [6:0]  opcode_t;  // major opcode field

    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // fetch unit handshake with the cache
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        DROP_ACK    // finish the handshake and drop the word
    } fetch_state_t;

    // cache miss handling
    typedef enum logic [1:0] {
        READY,
        MEM_REQ,
        MEM_DONE
    } cache_state_t;

    // sign extended J-type offset
    function automatic addr_t imm_j(input word_t ins);
        return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    endfunction

    // sign extended B-type offset
    function automatic addr_t imm_b(input word_t ins);
        return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    endfunction

endpackage

`default_nettype wire
